// ==== all.f ====
hw/branch_pkg.sv
hw/branch_ifs.sv
hw/branch_locator.sv
hw/packet_store.sv
hw/operand_gather.sv
hw/branch_resolve.sv
hw/branch_scan_ctrl.sv
hw/branch_detect_top.sv
bench/branch_checker.sv
bench/tb_branch_detect.sv

// ==== bench/branch_cases.txt ====
# name w0 w1 w2 w3 w4 w5 w6 w7 base_pc left0 right0 left1 right1
#   group_count mask0 mask1 mask2 redirect(0/1) redirect_pc   (all hex except counts)
no_branch 11111111 22222222 33333333 44444444 66666666 77777777 88888888 99999999 1000 0 0 0 0 1 ff 0 0 0 0
br3_not_taken 11111111 22222222 33333333 01041005 66666666 77777777 88888888 99999999 1000 1 2 0 0 2 0f f0 0 0 0
br2_taken_neg 11111111 22222222 fe083045 44444444 66666666 77777777 88888888 99999999 2000 5 5 0 0 1 07 0 0 1 1fe8
br5_taken_pos 11111111 22222222 33333333 44444444 66666666 00c4100d 88888888 99999999 4000 1 2 0 0 1 3f 0 0 1 4020
cond_eq 00441005 22222222 33333333 44444444 66666666 77777777 88888888 99999999 100 ffffffff 1 0 0 2 01 fe 0 0 0
cond_ne 0044100d 22222222 33333333 44444444 66666666 77777777 88888888 99999999 100 ffffffff 1 0 0 1 01 0 0 1 104
cond_lt 00441015 22222222 33333333 44444444 66666666 77777777 88888888 99999999 100 ffffffff 1 0 0 1 01 0 0 1 104
cond_ge 0044101d 22222222 33333333 44444444 66666666 77777777 88888888 99999999 100 ffffffff 1 0 0 2 01 fe 0 0 0
cond_ltu 00441025 22222222 33333333 44444444 66666666 77777777 88888888 99999999 100 ffffffff 1 0 0 2 01 fe 0 0 0
cond_geu 0044102d 22222222 33333333 44444444 66666666 77777777 88888888 99999999 100 ffffffff 1 0 0 1 01 0 0 1 104
cond_code6 00441035 22222222 33333333 44444444 66666666 77777777 88888888 99999999 100 1 1 0 0 2 01 fe 0 0 0
br7_not_taken 11111111 22222222 33333333 44444444 66666666 77777777 88888888 01041005 3000 1 2 0 0 1 ff 0 0 0 0
two_branches 11111111 01041005 33333333 44444444 00c4140d 77777777 88888888 99999999 5000 3 4 7 7 3 03 1c e0 0 0

// ==== bench/branch_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module branch_checker import branch_pkg::*; (
  input logic                              w_BranchFifoFire_1,
  input logic                              rstn,
  input logic                              i_packet_ready,
  input logic                              i_issue_valid,
  input logic [SLOT_COUNT-1:0]             i_issue_mask,
  input logic [SLOT_COUNT-1:0][INST_W-1:0] i_issue_slots,
  input logic                              i_redirect_valid,
  input logic [PC_W-1:0]                   i_redirect_pc,
  input logic                              i_grf_req,
  input logic [REG_W-1:0]                  i_rs1,
  input logic [REG_W-1:0]                  i_rs2,
  input logic                              i_bypass_req,
  input logic [DEP_W-1:0]                  i_dep_left,
  input logic [DEP_W-1:0]                  i_dep_right
);

  string                             name;
  logic [SLOT_COUNT-1:0][INST_W-1:0] packet;
  logic [2:0][SLOT_COUNT-1:0]        exp_masks;
  int                                exp_groups;
  int                                exp_redir;
  logic [PC_W-1:0]                   exp_pc;
  logic                              active = 1'b0;
  logic                              test_done = 1'b0;
  logic                              req_seen = 1'b0;
  logic                              redir_seen;
  logic                              in_flight = 1'b0;
  int                                groups_seen;
  int                                branches_seen;
  int                                test_errors;
  int                                total_errors = 0;
  int                                passed = 0;
  int                                failed = 0;

  task automatic start_test(input string n, input logic [SLOT_COUNT-1:0][INST_W-1:0] p,
                            input logic [2:0][SLOT_COUNT-1:0] m, input int groups,
                            input int redir, input logic [PC_W-1:0] rpc);
    name = n;
    packet = p;
    exp_masks = m;
    exp_groups = groups;
    exp_redir = redir;
    exp_pc = rpc;
    groups_seen = 0;
    branches_seen = 0;
    redir_seen = 1'b0;
    in_flight = 1'b0;
    test_errors = 0;
    test_done = 1'b0;
    active = 1'b1;
  endtask

  task automatic value_error(input string sig, input logic [31:0] got, input logic [31:0] exp);
    $display("** Error: %s: %s is %h, expected %h", name, sig, got, exp);
    test_errors++;
    total_errors++;
  endtask

  task automatic plain_error(input string what);
    $display("%s: %s", name, what);
    test_errors++;
    total_errors++;
  endtask

  // outputs right after reset
  task automatic check_idle();
    name = "reset";
    if (i_issue_valid) value_error("o_issue_valid", 32'(i_issue_valid), 32'h0);
    if (i_redirect_valid) value_error("o_redirect_valid", 32'(i_redirect_valid), 32'h0);
    if (i_grf_req) value_error("o_grf_req", 32'(i_grf_req), 32'h0);
    if (i_bypass_req) value_error("o_bypass_req", 32'(i_bypass_req), 32'h0);
    if (!i_packet_ready) value_error("o_packet_ready", 32'(i_packet_ready), 32'h1);
  endtask

  // word of the k-th branch in slot order
  function automatic logic [INST_W-1:0] nth_branch(input int k);
    int seen;
    seen = 0;
    nth_branch = '0;
    for (int i = 0; i < SLOT_COUNT; i++) begin
      if (packet[i][2:0] == 3'b101) begin
        if (seen == k) nth_branch = packet[i];
        seen++;
      end
    end
  endfunction

  task automatic check_request();
    logic [INST_W-1:0] w;
    logic              bypass;
    w = nth_branch(branches_seen);
    bypass = (w[8:6] != 3'd0) || (w[11:9] != 3'd0);
    branches_seen++;
    if (i_bypass_req != bypass) value_error("o_bypass_req", 32'(i_bypass_req), 32'(bypass));
    if (i_grf_req == bypass) value_error("o_grf_req", 32'(i_grf_req), 32'(!bypass));
    if (bypass) begin
      if (i_dep_left != w[8:6]) value_error("o_dep_left", 32'(i_dep_left), 32'(w[8:6]));
      if (i_dep_right != w[11:9]) value_error("o_dep_right", 32'(i_dep_right), 32'(w[11:9]));
    end else begin
      if (i_rs1 != w[16:12]) value_error("o_rs1", 32'(i_rs1), 32'(w[16:12]));
      if (i_rs2 != w[21:17]) value_error("o_rs2", 32'(i_rs2), 32'(w[21:17]));
    end
  endtask

  task automatic check_issue();
    logic [SLOT_COUNT-1:0] m;
    if (groups_seen >= exp_groups) begin
      plain_error("an issue group arrived after all expected groups");
    end else begin
      m = exp_masks[groups_seen];
      if (i_issue_mask != m) value_error("o_issue_mask", 32'(i_issue_mask), 32'(m));
      for (int i = 0; i < SLOT_COUNT; i++) begin
        if (i_issue_slots[i] != (m[i] ? packet[i] : 32'h0)) begin
          value_error($sformatf("o_issue_slots[%0d]", i), i_issue_slots[i],
                      m[i] ? packet[i] : 32'h0);
        end
      end
    end
    groups_seen++;
  endtask

  task automatic finish_test();
    if (groups_seen != exp_groups) begin
      plain_error($sformatf("saw %0d issue groups instead of %0d", groups_seen, exp_groups));
    end
    if (exp_redir != 0 && !redir_seen) plain_error("the expected redirect never came");
    if (test_errors == 0) passed++;
    else failed++;
    $display("test %s: %s", name, (test_errors == 0) ? "ok" : "failed");
    active = 1'b0;
    test_done <= 1'b1;
  endtask

  always @(posedge w_BranchFifoFire_1) begin
    if (rstn) begin
      // ready stays low from acceptance until the packet ends
      if (active) begin
        if (!i_packet_ready) begin
          in_flight = 1'b1;
        end else if (in_flight) begin
          plain_error("packet input ready again before the packet ended");
          in_flight = 1'b0;
        end
      end
      if (i_grf_req || i_bypass_req) begin
        if (!req_seen && active) check_request();
        req_seen = 1'b1;
      end else begin
        req_seen = 1'b0;
      end
      if (i_issue_valid || i_redirect_valid) begin
        if (i_packet_ready) plain_error("output pulse while the packet input was ready");
        if (!active) begin
          plain_error("issue or redirect pulse outside a packet");
        end else begin
          if (i_issue_valid) check_issue();
          if (i_redirect_valid) begin
            redir_seen = 1'b1;
            if (!i_issue_valid) plain_error("redirect came without the issue group of its branch");
            if (exp_redir == 0) plain_error("redirect on a packet that expects none");
            else if (i_redirect_pc != exp_pc) value_error("o_redirect_pc", i_redirect_pc, exp_pc);
          end
          if (i_redirect_valid || (i_issue_valid && i_issue_mask[SLOT_COUNT-1])) finish_test();
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== bench/tb_branch_detect.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_branch_detect import branch_pkg::*; ();

  localparam int MAX_TESTS = 32;

  logic                              w_BranchFifoFire_1;
  logic                              rstn;
  logic                              i_packet_valid;
  logic [SLOT_COUNT-1:0][INST_W-1:0] i_packet;
  logic [PC_W-1:0]                   i_packet_pc;
  logic                              o_packet_ready;
  logic                              o_grf_req;
  logic [REG_W-1:0]                  o_rs1;
  logic [REG_W-1:0]                  o_rs2;
  logic                              i_grf_valid;
  logic [DATA_W-1:0]                 i_grf_left;
  logic [DATA_W-1:0]                 i_grf_right;
  logic                              o_bypass_req;
  logic [DEP_W-1:0]                  o_dep_left;
  logic [DEP_W-1:0]                  o_dep_right;
  logic                              i_bypass_valid;
  logic [DATA_W-1:0]                 i_bypass_left;
  logic [DATA_W-1:0]                 i_bypass_right;
  logic                              o_issue_valid;
  logic [SLOT_COUNT-1:0]             o_issue_mask;
  logic [SLOT_COUNT-1:0][INST_W-1:0] o_issue_slots;
  logic                              o_redirect_valid;
  logic [PC_W-1:0]                   o_redirect_pc;

  // one entry per line of the cases file
  string                             names[MAX_TESTS];
  logic [SLOT_COUNT-1:0][INST_W-1:0] packets[MAX_TESTS];
  logic [PC_W-1:0]                   base_pcs[MAX_TESTS];
  logic [DATA_W-1:0]                 lefts[MAX_TESTS][2];
  logic [DATA_W-1:0]                 rights[MAX_TESTS][2];
  int                                group_counts[MAX_TESTS];
  logic [2:0][SLOT_COUNT-1:0]        masks[MAX_TESTS];
  int                                redirs[MAX_TESTS];
  logic [PC_W-1:0]                   redir_pcs[MAX_TESTS];
  int                                n_tests = 0;
  int                                cur = 0;
  int                                pair_idx = 0;
  logic [31:0]                       rnd = 32'hdd1f_0bf0;

  branch_detect_top i_branch_detect_top (.*);

  branch_checker i_checker (
    .w_BranchFifoFire_1, .rstn,
    .i_packet_ready (o_packet_ready),
    .i_issue_valid (o_issue_valid),
    .i_issue_mask (o_issue_mask),
    .i_issue_slots (o_issue_slots),
    .i_redirect_valid (o_redirect_valid),
    .i_redirect_pc (o_redirect_pc),
    .i_grf_req (o_grf_req), .i_rs1 (o_rs1), .i_rs2 (o_rs2),
    .i_bypass_req (o_bypass_req), .i_dep_left (o_dep_left), .i_dep_right (o_dep_right)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic load_cases();
    int                   fd;
    int                   cnt;
    string                line;
    string                nm;
    logic [INST_W-1:0]    w[SLOT_COUNT];
    logic [31:0]          pc, l0, r0, l1, r1, m0, m1, m2, rpc;
    int                   ng, rv;
    fd = $fopen("bench/branch_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open bench/branch_cases.txt");
      return;
    end
    while (!$feof(fd) && n_tests < MAX_TESTS) begin
      cnt = $fgets(line, fd);
      if (cnt > 1 && line.getc(0) != "#") begin
        cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %d %h %h %h %d %h",
                      nm, w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7], pc,
                      l0, r0, l1, r1, ng, m0, m1, m2, rv, rpc);
        if (cnt == 20) begin
          names[n_tests] = nm;
          for (int i = 0; i < SLOT_COUNT; i++) packets[n_tests][i] = w[i];
          base_pcs[n_tests] = pc;
          lefts[n_tests][0] = l0;
          rights[n_tests][0] = r0;
          lefts[n_tests][1] = l1;
          rights[n_tests][1] = r1;
          group_counts[n_tests] = ng;
          masks[n_tests] = {m2[7:0], m1[7:0], m0[7:0]};
          redirs[n_tests] = rv;
          redir_pcs[n_tests] = rpc;
          n_tests++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic run_test(input int t);
    @(posedge w_BranchFifoFire_1);
    while (!o_packet_ready) @(posedge w_BranchFifoFire_1);
    cur = t;
    pair_idx = 0;
    i_checker.start_test(names[t], packets[t], masks[t], group_counts[t], redirs[t],
                         redir_pcs[t]);
    i_packet <= packets[t];
    i_packet_pc <= base_pcs[t];
    i_packet_valid <= 1'b1;
    @(posedge w_BranchFifoFire_1);
    i_packet_valid <= 1'b0;
    while (!i_checker.test_done) @(posedge w_BranchFifoFire_1);
    repeat (2) @(posedge w_BranchFifoFire_1);
  endtask

  initial begin
    w_BranchFifoFire_1 = 1'b0;
    forever #50 w_BranchFifoFire_1 = ~w_BranchFifoFire_1;
  end

  // answers each request after 1 to 4 cycles
  initial begin
    int d;
    forever begin
      @(posedge w_BranchFifoFire_1);
      if (rstn && (o_grf_req || o_bypass_req)) begin
        rnd = xorshift(rnd);
        d = int'(rnd % 4) + 1;
        repeat (d - 1) @(posedge w_BranchFifoFire_1);
        if (o_grf_req) begin
          i_grf_left <= lefts[cur][pair_idx];
          i_grf_right <= rights[cur][pair_idx];
          i_grf_valid <= 1'b1;
        end else begin
          i_bypass_left <= lefts[cur][pair_idx];
          i_bypass_right <= rights[cur][pair_idx];
          i_bypass_valid <= 1'b1;
        end
        pair_idx = (pair_idx + 1) % 2;
        @(posedge w_BranchFifoFire_1);
        i_grf_valid <= 1'b0;
        i_bypass_valid <= 1'b0;
      end
    end
  end

  // run limit scales with the number of tests
  initial begin
    wait (n_tests > 0);
    repeat (n_tests * 40 + 10) @(posedge w_BranchFifoFire_1);
    $display("watchdog expired before all tests finished");
    $display("** FAIL **");
    $finish;
  end

  initial begin
    rstn = 1'b0;
    i_packet_valid = 1'b0;
    i_packet = '0;
    i_packet_pc = '0;
    i_grf_valid = 1'b0;
    i_grf_left = '0;
    i_grf_right = '0;
    i_bypass_valid = 1'b0;
    i_bypass_left = '0;
    i_bypass_right = '0;
    load_cases();
    repeat (3) @(posedge w_BranchFifoFire_1);
    rstn <= 1'b1;
    @(posedge w_BranchFifoFire_1);
    i_checker.check_idle();
    for (int t = 0; t < n_tests; t++) run_test(t);
    $display("tests %0d, passed %0d, failed %0d, errors %0d", n_tests, i_checker.passed,
             i_checker.failed, i_checker.total_errors);
    if (n_tests > 0 && i_checker.total_errors == 0) begin
      $display("** PASS **");
    end else begin
      if (n_tests == 0) $display("no test cases were read");
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/branch_detect_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module branch_detect_top import branch_pkg::*; (
  input  logic                              w_BranchFifoFire_1,
  input  logic                              rstn,
  input  logic                              i_packet_valid,
  input  logic [SLOT_COUNT-1:0][INST_W-1:0] i_packet,
  input  logic [PC_W-1:0]                   i_packet_pc,
  output logic                              o_packet_ready,
  output logic                              o_grf_req,
  output logic [REG_W-1:0]                  o_rs1,
  output logic [REG_W-1:0]                  o_rs2,
  input  logic                              i_grf_valid,
  input  logic [DATA_W-1:0]                 i_grf_left,
  input  logic [DATA_W-1:0]                 i_grf_right,
  output logic                              o_bypass_req,
  output logic [DEP_W-1:0]                  o_dep_left,
  output logic [DEP_W-1:0]                  o_dep_right,
  input  logic                              i_bypass_valid,
  input  logic [DATA_W-1:0]                 i_bypass_left,
  input  logic [DATA_W-1:0]                 i_bypass_right,
  output logic                              o_issue_valid,
  output logic [SLOT_COUNT-1:0]             o_issue_mask,
  output logic [SLOT_COUNT-1:0][INST_W-1:0] o_issue_slots,
  output logic                              o_redirect_valid,
  output logic [PC_W-1:0]                   o_redirect_pc
);

  logic                  fetch_start;
  logic                  result_valid;
  logic                  taken;
  logic                  issue_fire;
  logic [SLOT_IDX_W-1:0] issue_lo;
  logic [SLOT_IDX_W-1:0] issue_hi;
  logic [INST_W-1:0]     branch_word;
  logic [PC_W-1:0]       branch_pc;

  branch_list_if list_bus ();
  operand_if     opnd_bus ();

  branch_scan_ctrl i_branch_scan_ctrl (
    .w_BranchFifoFire_1, .rstn, .i_packet_valid, .o_packet_ready,
    .list (list_bus.ctrl),
    .o_fetch_start (fetch_start),
    .i_result_valid (result_valid),
    .i_taken (taken),
    .o_issue_fire (issue_fire),
    .o_issue_lo (issue_lo),
    .o_issue_hi (issue_hi),
    .o_issue_valid, .o_redirect_valid
  );

  branch_locator i_branch_locator (
    .w_BranchFifoFire_1, .rstn, .i_packet,
    .list (list_bus.locator)
  );

  packet_store i_packet_store (
    .w_BranchFifoFire_1, .rstn,
    .i_load (list_bus.load),
    .i_packet, .i_packet_pc,
    .i_branch_index (list_bus.index),
    .o_branch_word (branch_word),
    .o_branch_pc (branch_pc),
    .i_issue_fire (issue_fire),
    .i_issue_lo (issue_lo),
    .i_issue_hi (issue_hi),
    .o_issue_mask, .o_issue_slots
  );

  operand_gather i_operand_gather (
    .w_BranchFifoFire_1, .rstn,
    .i_fetch_start (fetch_start),
    .i_branch_word (branch_word),
    .i_branch_pc (branch_pc),
    .o_grf_req, .o_rs1, .o_rs2, .i_grf_valid, .i_grf_left, .i_grf_right,
    .o_bypass_req, .o_dep_left, .o_dep_right,
    .i_bypass_valid, .i_bypass_left, .i_bypass_right,
    .opnd (opnd_bus.source)
  );

  branch_resolve i_branch_resolve (
    .w_BranchFifoFire_1, .rstn,
    .opnd (opnd_bus.sink),
    .o_result_valid (result_valid),
    .o_taken (taken),
    .o_target (o_redirect_pc)
  );

endmodule

`default_nettype wire

// ==== hw/branch_ifs.sv ====
`timescale 1ns/10ps
`default_nettype none

// pending branch list between controller and locator
interface branch_list_if import branch_pkg::*; ();
  logic                  load;
  logic                  advance;
  logic                  any;
  logic [SLOT_IDX_W-1:0] index;
  logic                  last;

  modport ctrl (output load, output advance, input any, input index, input last);
  modport locator (input load, input advance, output any, output index, output last);
endinterface

// latched branch operands toward the compare stage
interface operand_if import branch_pkg::*; ();
  logic                opnd_valid;
  logic [COND_W-1:0]   cond;
  logic [DATA_W-1:0]   left;
  logic [DATA_W-1:0]   right;
  logic [PC_W-1:0]     pc;
  logic [OFFSET_W-1:0] offset;

  modport source (
    output opnd_valid, output cond, output left, output right, output pc, output offset
  );
  modport sink (
    input opnd_valid, input cond, input left, input right, input pc, input offset
  );
endinterface

`default_nettype wire

// ==== hw/branch_locator.sv ====
`timescale 1ns/10ps
`default_nettype none

module branch_locator import branch_pkg::*; (
  input  logic                              w_BranchFifoFire_1,
  input  logic                              rstn,
  input  logic [SLOT_COUNT-1:0][INST_W-1:0] i_packet,
  branch_list_if.locator                    list
);

  logic [SLOT_COUNT-1:0] r_pending;
  logic [SLOT_COUNT-1:0] pending_rest;
  logic [SLOT_IDX_W-1:0] lowest;

  // pending list with its lowest bit removed
  assign pending_rest = r_pending & (r_pending - 1'b1);

  always_ff @(posedge w_BranchFifoFire_1 or negedge rstn) begin
    if (!rstn) begin
      r_pending <= '0;
    end else if (list.load) begin
      for (int i = 0; i < SLOT_COUNT; i++) begin
        r_pending[i] <= (i_packet[i][OPC_LSB +: OPC_W] == OP_BRANCH);
      end
    end else if (list.advance) begin
      r_pending <= pending_rest;
    end
  end

  // priority encoder where the lowest slot wins
  always_comb begin
    lowest = '0;
    for (int i = SLOT_COUNT - 1; i >= 0; i--) begin
      if (r_pending[i]) lowest = SLOT_IDX_W'(i);
    end
  end

  assign list.any = |r_pending;
  assign list.index = lowest;
  assign list.last = list.any && (pending_rest == '0);

  a_advance_needs_branch: assert property (
    @(posedge w_BranchFifoFire_1) disable iff (!rstn) list.advance |-> list.any
  );

endmodule

`default_nettype wire

// ==== hw/branch_pkg.sv ====
`default_nettype none

package branch_pkg;

  localparam int SLOT_COUNT = 8;
  localparam int SLOT_IDX_W = 3;
  localparam int INST_W = 32;
  localparam int DATA_W = 32;
  localparam int PC_W = 32;
  localparam int DEP_W = 3;
  localparam int REG_W = 5;
  localparam int OFFSET_W = 10;
  localparam int OPC_W = 3;
  localparam int COND_W = 3;

  // instruction word layout from bit 0 up
  localparam int OPC_LSB = 0;
  localparam int COND_LSB = 3;
  localparam int DEPL_LSB = 6;
  localparam int DEPR_LSB = 9;
  localparam int RS1_LSB = 12;
  localparam int RS2_LSB = 17;
  localparam int OFF_LSB = 22;

  localparam logic [OPC_W-1:0] OP_BRANCH = 3'b101;

  // codes 6 and 7 never taken
  localparam logic [COND_W-1:0] COND_EQ = 3'd0;
  localparam logic [COND_W-1:0] COND_NE = 3'd1;
  localparam logic [COND_W-1:0] COND_LT = 3'd2;
  localparam logic [COND_W-1:0] COND_GE = 3'd3;
  localparam logic [COND_W-1:0] COND_LTU = 3'd4;
  localparam logic [COND_W-1:0] COND_GEU = 3'd5;

  localparam logic [SLOT_IDX_W-1:0] LAST_SLOT = SLOT_IDX_W'(SLOT_COUNT - 1);

  // scan controller states
  localparam int STATE_W = 3;
  localparam logic [STATE_W-1:0] ST_IDLE = 3'd0;
  localparam logic [STATE_W-1:0] ST_SCAN = 3'd1;
  localparam logic [STATE_W-1:0] ST_FETCH = 3'd2;
  localparam logic [STATE_W-1:0] ST_WAIT = 3'd3;
  localparam logic [STATE_W-1:0] ST_TAIL = 3'd4;

endpackage

`default_nettype wire

// ==== hw/branch_resolve.sv ====
`timescale 1ns/10ps
`default_nettype none

module branch_resolve import branch_pkg::*; (
  input  logic            w_BranchFifoFire_1,
  input  logic            rstn,
  operand_if.sink         opnd,
  output logic            o_result_valid,
  output logic            o_taken,
  output logic [PC_W-1:0] o_target
);

  logic            cond_true;
  logic [PC_W-1:0] target;

  always_comb begin
    case (opnd.cond)
      COND_EQ:  cond_true = (opnd.left == opnd.right);
      COND_NE:  cond_true = (opnd.left != opnd.right);
      COND_LT:  cond_true = ($signed(opnd.left) < $signed(opnd.right));
      COND_GE:  cond_true = ($signed(opnd.left) >= $signed(opnd.right));
      COND_LTU: cond_true = (opnd.left < opnd.right);
      COND_GEU: cond_true = (opnd.left >= opnd.right);
      default:  cond_true = 1'b0;
    endcase
  end

  // sign extended word offset
  assign target = opnd.pc + {{(PC_W - OFFSET_W - 2){opnd.offset[OFFSET_W-1]}},
                             opnd.offset, 2'b00};

  always_ff @(posedge w_BranchFifoFire_1 or negedge rstn) begin
    if (!rstn) o_result_valid <= 1'b0;
    else o_result_valid <= opnd.opnd_valid;
  end

  always_ff @(posedge w_BranchFifoFire_1) begin
    if (opnd.opnd_valid) begin
      o_taken <= cond_true;
      o_target <= target;
    end
  end

endmodule

`default_nettype wire

// ==== hw/branch_scan_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module branch_scan_ctrl import branch_pkg::*; (
  input  logic                  w_BranchFifoFire_1,
  input  logic                  rstn,
  input  logic                  i_packet_valid,
  output logic                  o_packet_ready,
  branch_list_if.ctrl           list,
  output logic                  o_fetch_start,
  input  logic                  i_result_valid,
  input  logic                  i_taken,
  output logic                  o_issue_fire,
  output logic [SLOT_IDX_W-1:0] o_issue_lo,
  output logic [SLOT_IDX_W-1:0] o_issue_hi,
  output logic                  o_issue_valid,
  output logic                  o_redirect_valid
);

  logic [STATE_W-1:0]    r_state;
  logic [STATE_W-1:0]    nxt_state;
  logic [SLOT_IDX_W-1:0] r_next;
  logic                  r_more;
  logic                  branch_done;

  assign o_packet_ready = (r_state == ST_IDLE);
  assign list.load = o_packet_ready && i_packet_valid;
  assign branch_done = (r_state == ST_WAIT) && i_result_valid;
  assign list.advance = branch_done;
  assign o_fetch_start = (r_state == ST_FETCH);
  // each group starts one past the previous branch
  assign o_issue_lo = r_next;

  always_comb begin
    nxt_state = r_state;
    o_issue_fire = 1'b0;
    o_issue_hi = LAST_SLOT;
    case (r_state)
      ST_IDLE: begin
        if (list.load) nxt_state = ST_SCAN;
      end
      ST_SCAN: begin
        if (list.any) begin
          nxt_state = ST_FETCH;
        end else begin
          o_issue_fire = 1'b1;
          nxt_state = ST_TAIL;
        end
      end
      ST_FETCH: nxt_state = ST_WAIT;
      ST_WAIT: begin
        if (i_result_valid) begin
          o_issue_fire = 1'b1;
          o_issue_hi = list.index;
          nxt_state = (i_taken || list.last) ? ST_TAIL : ST_FETCH;
        end
      end
      ST_TAIL: begin
        // remaining slots after a not-taken last branch
        if (r_more) o_issue_fire = 1'b1;
        else nxt_state = ST_IDLE;
      end
      default: nxt_state = ST_IDLE;
    endcase
  end

  always_ff @(posedge w_BranchFifoFire_1 or negedge rstn) begin
    if (!rstn) begin
      r_state <= ST_IDLE;
      r_next <= '0;
      r_more <= 1'b0;
      o_issue_valid <= 1'b0;
      o_redirect_valid <= 1'b0;
    end else begin
      r_state <= nxt_state;
      o_issue_valid <= o_issue_fire;
      o_redirect_valid <= branch_done && i_taken;
      if (list.load) r_next <= '0;
      else if (branch_done) r_next <= list.index + 1'b1;
      if (branch_done) r_more <= !i_taken && list.last && (list.index != LAST_SLOT);
      else if (r_state == ST_TAIL) r_more <= 1'b0;
    end
  end

  a_no_issue_while_ready: assert property (
    @(posedge w_BranchFifoFire_1) disable iff (!rstn) !(o_issue_valid && o_packet_ready)
  );

endmodule

`default_nettype wire

// ==== hw/operand_gather.sv ====
`timescale 1ns/10ps
`default_nettype none

module operand_gather import branch_pkg::*; (
  input  logic               w_BranchFifoFire_1,
  input  logic               rstn,
  input  logic               i_fetch_start,
  input  logic [INST_W-1:0]  i_branch_word,
  input  logic [PC_W-1:0]    i_branch_pc,
  output logic               o_grf_req,
  output logic [REG_W-1:0]   o_rs1,
  output logic [REG_W-1:0]   o_rs2,
  input  logic               i_grf_valid,
  input  logic [DATA_W-1:0]  i_grf_left,
  input  logic [DATA_W-1:0]  i_grf_right,
  output logic               o_bypass_req,
  output logic [DEP_W-1:0]   o_dep_left,
  output logic [DEP_W-1:0]   o_dep_right,
  input  logic               i_bypass_valid,
  input  logic [DATA_W-1:0]  i_bypass_left,
  input  logic [DATA_W-1:0]  i_bypass_right,
  operand_if.source          opnd
);

  logic need_bypass;
  logic grf_hit;
  logic bypass_hit;

  // any nonzero tag means a value still in flight
  assign need_bypass = (i_branch_word[DEPL_LSB +: DEP_W] != '0) ||
                       (i_branch_word[DEPR_LSB +: DEP_W] != '0);
  assign grf_hit = o_grf_req && i_grf_valid;
  assign bypass_hit = o_bypass_req && i_bypass_valid;

  always_ff @(posedge w_BranchFifoFire_1 or negedge rstn) begin
    if (!rstn) begin
      o_grf_req <= 1'b0;
      o_bypass_req <= 1'b0;
      opnd.opnd_valid <= 1'b0;
    end else begin
      if (i_fetch_start) begin
        o_grf_req <= !need_bypass;
        o_bypass_req <= need_bypass;
      end else begin
        if (grf_hit) o_grf_req <= 1'b0;
        if (bypass_hit) o_bypass_req <= 1'b0;
      end
      opnd.opnd_valid <= grf_hit || bypass_hit;
    end
  end

  always_ff @(posedge w_BranchFifoFire_1) begin
    if (i_fetch_start) begin
      o_rs1 <= i_branch_word[RS1_LSB +: REG_W];
      o_rs2 <= i_branch_word[RS2_LSB +: REG_W];
      o_dep_left <= i_branch_word[DEPL_LSB +: DEP_W];
      o_dep_right <= i_branch_word[DEPR_LSB +: DEP_W];
      opnd.cond <= i_branch_word[COND_LSB +: COND_W];
      opnd.offset <= i_branch_word[OFF_LSB +: OFFSET_W];
      opnd.pc <= i_branch_pc;
    end
    if (grf_hit) begin
      opnd.left <= i_grf_left;
      opnd.right <= i_grf_right;
    end else if (bypass_hit) begin
      opnd.left <= i_bypass_left;
      opnd.right <= i_bypass_right;
    end
  end

  a_one_source: assert property (
    @(posedge w_BranchFifoFire_1) disable iff (!rstn) !(o_grf_req && o_bypass_req)
  );

endmodule

`default_nettype wire

// ==== hw/packet_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module packet_store import branch_pkg::*; (
  input  logic                              w_BranchFifoFire_1,
  input  logic                              rstn,
  input  logic                              i_load,
  input  logic [SLOT_COUNT-1:0][INST_W-1:0] i_packet,
  input  logic [PC_W-1:0]                   i_packet_pc,
  input  logic [SLOT_IDX_W-1:0]             i_branch_index,
  output logic [INST_W-1:0]                 o_branch_word,
  output logic [PC_W-1:0]                   o_branch_pc,
  input  logic                              i_issue_fire,
  input  logic [SLOT_IDX_W-1:0]             i_issue_lo,
  input  logic [SLOT_IDX_W-1:0]             i_issue_hi,
  output logic [SLOT_COUNT-1:0]             o_issue_mask,
  output logic [SLOT_COUNT-1:0][INST_W-1:0] o_issue_slots
);

  logic [SLOT_COUNT-1:0][INST_W-1:0] r_packet;
  logic [PC_W-1:0]                   r_base_pc;
  logic [SLOT_COUNT-1:0]             range_mask;

  always_ff @(posedge w_BranchFifoFire_1) begin
    if (i_load) begin
      r_packet <= i_packet;
      r_base_pc <= i_packet_pc;
    end
  end

  assign o_branch_word = r_packet[i_branch_index];
  // four bytes per slot
  assign o_branch_pc = r_base_pc + PC_W'({i_branch_index, 2'b00});

  always_comb begin
    for (int i = 0; i < SLOT_COUNT; i++) begin
      range_mask[i] = (SLOT_IDX_W'(i) >= i_issue_lo) && (SLOT_IDX_W'(i) <= i_issue_hi);
      o_issue_slots[i] = o_issue_mask[i] ? r_packet[i] : '0;
    end
  end

  always_ff @(posedge w_BranchFifoFire_1 or negedge rstn) begin
    if (!rstn) o_issue_mask <= '0;
    else if (i_issue_fire) o_issue_mask <= range_mask;
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_branch_detect -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && { echo "simulation reported failure"; exit 1; } || exit 0
